/* logic/bus_pkg.sv */
// Bus word types, register-select and sequencer-state enums
`default_nettype none

`include "io_defs.svh"

package bus_pkg;

    typedef logic [`IO_ADDR_W-1:0] addr_t;
    typedef logic [`IO_DATA_W-1:0] word_t;

    // Decoded register targets
    typedef enum logic [3:0] {
        SEL_SPI_DATA,
        SEL_SPI_CS,
        SEL_SPI_NINT,
        SEL_GPIO,
        SEL_T1_VAL,
        SEL_T1_CTRL,
        SEL_T2_VAL,
        SEL_T2_CTRL,
        SEL_BOOT,
        SEL_NONE
    } reg_sel_t;

    // Transaction sequencer
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SPI_WAIT,
        ST_DELAY,
        ST_DONE,
        ST_RELEASE
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/bus_sequencer.sv */
// Bus address decoder, transaction FSM, write strobes and read-word latch
`default_nettype none

`include "io_defs.svh"

module bus_sequencer (
    input  wire                          clk,
    input  wire                          reset,
    input  wire bus_pkg::addr_t          i_bus_addr,
    input  wire bus_pkg::word_t          i_bus_data,
    input  wire                          i_bus_we,
    input  wire                          i_bus_start,
    output bus_pkg::word_t               o_bus_q,
    output logic                         o_bus_done,
    output logic                         o_cs_we,
    output logic                         o_gpo_we,
    output bus_pkg::word_t               o_wr_data,
    output logic                         o_spi_start,
    output periph_pkg::spi_byte_t        o_spi_tx,
    input  wire                          i_spi_done,
    input  wire periph_pkg::spi_byte_t   i_spi_rx,
    input  wire                          i_spi_cs,
    input  wire                          i_spi_nint,
    input  wire periph_pkg::gpio_t       i_gpo,
    input  wire periph_pkg::gpio_t       i_gpi,
    input  wire                          i_boot_mode,
    output logic                         o_t1_set,
    output logic                         o_t1_go,
    output logic                         o_t2_set,
    output logic                         o_t2_go
);

    // Entering ST_DELAY already costs one cycle, ST_DONE another
    localparam logic [3:0] DELAY_LOAD = 4'(`IO_UNMAPPED_DELAY - 2);

    bus_pkg::reg_sel_t   sel;
    bus_pkg::seq_state_t state;
    bus_pkg::seq_state_t state_next;
    bus_pkg::word_t      read_word;
    logic [3:0]          delay_cnt;
    logic                accept;
    logic                wr;

    // --------------------------------------------------
    // Address decode and read mux
    // --------------------------------------------------
    always_comb
    begin
        case (i_bus_addr)
            `IO_A_SPI_DATA: sel = bus_pkg::SEL_SPI_DATA;
            `IO_A_SPI_CS:   sel = bus_pkg::SEL_SPI_CS;
            `IO_A_SPI_NINT: sel = bus_pkg::SEL_SPI_NINT;
            `IO_A_GPIO:     sel = bus_pkg::SEL_GPIO;
            `IO_A_T1_VAL:   sel = bus_pkg::SEL_T1_VAL;
            `IO_A_T1_CTRL:  sel = bus_pkg::SEL_T1_CTRL;
            `IO_A_T2_VAL:   sel = bus_pkg::SEL_T2_VAL;
            `IO_A_T2_CTRL:  sel = bus_pkg::SEL_T2_CTRL;
            `IO_A_BOOT:     sel = bus_pkg::SEL_BOOT;
            default:        sel = bus_pkg::SEL_NONE;
        endcase
    end

    // Timers and unmapped addresses read as zero
    always_comb
    begin
        case (sel)
            bus_pkg::SEL_SPI_DATA: read_word = {24'd0, i_spi_rx};
            bus_pkg::SEL_SPI_CS:   read_word = {31'd0, i_spi_cs};
            bus_pkg::SEL_SPI_NINT: read_word = {31'd0, i_spi_nint};
            bus_pkg::SEL_GPIO:     read_word = {24'd0, i_gpo, i_gpi};
            bus_pkg::SEL_BOOT:     read_word = {31'd0, i_boot_mode};
            default:               read_word = '0;
        endcase
    end

    // --------------------------------------------------
    // Write strobes, one per write, in the accept cycle
    // --------------------------------------------------
    assign accept = (state == bus_pkg::ST_IDLE) && i_bus_start;
    assign wr     = accept && i_bus_we;

    assign o_cs_we     = wr && (sel == bus_pkg::SEL_SPI_CS);
    assign o_gpo_we    = wr && (sel == bus_pkg::SEL_GPIO);
    assign o_spi_start = wr && (sel == bus_pkg::SEL_SPI_DATA);
    assign o_t1_set    = wr && (sel == bus_pkg::SEL_T1_VAL);
    assign o_t1_go     = wr && (sel == bus_pkg::SEL_T1_CTRL);
    assign o_t2_set    = wr && (sel == bus_pkg::SEL_T2_VAL);
    assign o_t2_go     = wr && (sel == bus_pkg::SEL_T2_CTRL);
    assign o_wr_data   = i_bus_data;
    assign o_spi_tx    = i_bus_data[7:0];

    // --------------------------------------------------
    // Transaction FSM
    // --------------------------------------------------
    always_comb
    begin
        state_next = state;
        case (state)
            bus_pkg::ST_IDLE:
            begin
                if (accept)
                begin
                    if (sel == bus_pkg::SEL_NONE)
                        state_next = bus_pkg::ST_DELAY;
                    else if (o_spi_start)
                        state_next = bus_pkg::ST_SPI_WAIT;
                    else
                        state_next = bus_pkg::ST_DONE;
                end
            end
            bus_pkg::ST_SPI_WAIT:
                if (i_spi_done) state_next = bus_pkg::ST_DONE;
            bus_pkg::ST_DELAY:
                if (delay_cnt == 4'd0) state_next = bus_pkg::ST_DONE;
            bus_pkg::ST_DONE:
                state_next = bus_pkg::ST_RELEASE;
            // Master must drop start before the next request
            bus_pkg::ST_RELEASE:
                if (!i_bus_start) state_next = bus_pkg::ST_IDLE;
            default:
                state_next = bus_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= bus_pkg::ST_IDLE;
            delay_cnt <= 4'd0;
        end
        else
        begin
            state <= state_next;
            if (accept)
                delay_cnt <= DELAY_LOAD;
            else if (state == bus_pkg::ST_DELAY && delay_cnt != 4'd0)
                delay_cnt <= delay_cnt - 4'd1;
        end
    end

    // Read word captured on the way into ST_DONE
    always_ff @(posedge clk)
    begin
        if (state_next == bus_pkg::ST_DONE)
            o_bus_q <= read_word;
    end

    assign o_bus_done = (state == bus_pkg::ST_DONE);

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        o_bus_done |=> !o_bus_done);

endmodule

`default_nettype wire

/* logic/io_defs.svh */
// Bus widths, register map, SPI clock divider and unmapped-access delay
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define IO_ADDR_W 27
`define IO_DATA_W 32

// --------------------------------------------------
// Register map
// --------------------------------------------------
// SPI port (CH376T side)
`define IO_A_SPI_DATA 27'hC0272B
`define IO_A_SPI_CS   27'hC0272C
`define IO_A_SPI_NINT 27'hC0272D

// GPO in bits 7:4, GPI in bits 3:0
`define IO_A_GPIO     27'hC02737

// One-shot timers, value then control
`define IO_A_T1_VAL   27'hC02739
`define IO_A_T1_CTRL  27'hC0273A
`define IO_A_T2_VAL   27'hC0273B
`define IO_A_T2_CTRL  27'hC0273C

`define IO_A_BOOT     27'hC02741

// --------------------------------------------------
// Timing
// --------------------------------------------------
// Clock cycles per SCLK half period, 2 or more
`define IO_SPI_HALF_BIT 2
// Start-to-done cycles for an unmapped address, 2 or more
`define IO_UNMAPPED_DELAY 2

`endif

/* logic/io_registers.sv */
// SPI chip-select and GPO output registers
`default_nettype none

module io_registers (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      i_cs_we,
    input  wire                      i_gpo_we,
    input  wire bus_pkg::word_t      i_wr_data,
    output logic                     o_spi_cs,
    output periph_pkg::gpio_t        o_gpo
);

    // --------------------------------------------------
    // Chip select, deasserted (high) out of reset
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            o_spi_cs <= 1'b1;
        else if (i_cs_we)
            o_spi_cs <= i_wr_data[0];
    end

    // --------------------------------------------------
    // GPO lives in the upper nibble of the GPIO word
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            o_gpo <= '0;
        else if (i_gpo_we)
            o_gpo <= i_wr_data[7:4];
    end

    // Decoder selects a single register per access
    a_one_we: assert property (@(posedge clk) disable iff (reset)
        !(i_cs_we && i_gpo_we));

endmodule

`default_nettype wire

/* logic/io_unit.sv */
// I/O unit top: bus sequencer, CS/GPO registers, SPI master, two OS timers
`default_nettype none

module io_unit (
    input  wire                      clk,
    input  wire                      reset,

    // CPU bus
    input  wire bus_pkg::addr_t      i_bus_addr,
    input  wire bus_pkg::word_t      i_bus_data,
    input  wire                      i_bus_we,
    input  wire                      i_bus_start,
    output wire bus_pkg::word_t      o_bus_q,
    output wire                      o_bus_done,

    // SPI port
    output wire                      o_spi_sclk,
    output wire                      o_spi_mosi,
    input  wire                      i_spi_miso,
    output wire                      o_spi_cs,
    input  wire                      i_spi_nint,

    // GPIO, timers, boot mode
    input  wire periph_pkg::gpio_t   i_gpi,
    output wire periph_pkg::gpio_t   o_gpo,
    output wire                      o_t1_irq,
    output wire                      o_t2_irq,
    input  wire                      i_boot_mode
);

    bus_pkg::word_t        wr_data;
    logic                  cs_we;
    logic                  gpo_we;
    logic                  spi_start;
    periph_pkg::spi_byte_t spi_tx;
    logic                  spi_done;
    periph_pkg::spi_byte_t spi_rx;
    logic                  t1_set;
    logic                  t1_go;
    logic                  t2_set;
    logic                  t2_go;

    bus_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .i_bus_addr  (i_bus_addr),
        .i_bus_data  (i_bus_data),
        .i_bus_we    (i_bus_we),
        .i_bus_start (i_bus_start),
        .o_bus_q     (o_bus_q),
        .o_bus_done  (o_bus_done),
        .o_cs_we     (cs_we),
        .o_gpo_we    (gpo_we),
        .o_wr_data   (wr_data),
        .o_spi_start (spi_start),
        .o_spi_tx    (spi_tx),
        .i_spi_done  (spi_done),
        .i_spi_rx    (spi_rx),
        .i_spi_cs    (o_spi_cs),
        .i_spi_nint  (i_spi_nint),
        .i_gpo       (o_gpo),
        .i_gpi       (i_gpi),
        .i_boot_mode (i_boot_mode),
        .o_t1_set    (t1_set),
        .o_t1_go     (t1_go),
        .o_t2_set    (t2_set),
        .o_t2_go     (t2_go)
    );

    io_registers u_regs (
        .clk       (clk),
        .reset     (reset),
        .i_cs_we   (cs_we),
        .i_gpo_we  (gpo_we),
        .i_wr_data (wr_data),
        .o_spi_cs  (o_spi_cs),
        .o_gpo     (o_gpo)
    );

    spi_master u_spi (
        .clk     (clk),
        .reset   (reset),
        .i_start (spi_start),
        .i_tx    (spi_tx),
        .o_done  (spi_done),
        .o_rx    (spi_rx),
        .o_sclk  (o_spi_sclk),
        .o_mosi  (o_spi_mosi),
        .i_miso  (i_spi_miso)
    );

    // Timer value comes straight from the bus data word
    os_timer u_t1 (
        .clk     (clk),
        .reset   (reset),
        .i_set   (t1_set),
        .i_go    (t1_go),
        .i_value (wr_data),
        .o_irq   (o_t1_irq)
    );

    os_timer u_t2 (
        .clk     (clk),
        .reset   (reset),
        .i_set   (t2_set),
        .i_go    (t2_go),
        .i_value (wr_data),
        .o_irq   (o_t2_irq)
    );

endmodule

`default_nettype wire

/* logic/os_timer.sv */
// One-shot OS timer with reload register and interrupt pulse
`default_nettype none

module os_timer (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            i_set,
    input  wire                            i_go,
    input  wire periph_pkg::timer_count_t  i_value,
    output logic                           o_irq
);

    periph_pkg::timer_count_t reload;
    periph_pkg::timer_count_t count;

    // --------------------------------------------------
    // Countdown, zero means stopped
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reload <= '0;
            count  <= '0;
            o_irq  <= 1'b0;
        end
        else
        begin
            o_irq <= 1'b0;
            if (i_set)
                reload <= i_value;

            // A go restarts from the stored value
            if (i_go)
                count <= reload;
            else if (count != '0)
            begin
                count <= count - 1'b1;
                // Fires V edges after go
                if (count == periph_pkg::timer_count_t'(1))
                    o_irq <= 1'b1;
            end
        end
    end

    a_irq_pulse: assert property (@(posedge clk) disable iff (reset)
        o_irq |=> !o_irq);

endmodule

`default_nettype wire

/* logic/periph_pkg.sv */
// Peripheral types: SPI byte, GPIO nibble, timer count, SPI state enum
`default_nettype none

package periph_pkg;

    // One SPI exchange
    typedef logic [7:0] spi_byte_t;

    // Each GPIO side is four pins
    typedef logic [3:0] gpio_t;

    // OS timer reload and countdown
    typedef logic [31:0] timer_count_t;

    // SPI byte shifter
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_END
    } spi_state_t;

endpackage

`default_nettype wire

/* logic/spi_master.sv */
// Mode-0 SPI byte exchange, MSB first, with held receive byte
`default_nettype none

`include "io_defs.svh"

module spi_master (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          i_start,
    input  wire periph_pkg::spi_byte_t   i_tx,
    output logic                         o_done,
    output periph_pkg::spi_byte_t        o_rx,
    output logic                         o_sclk,
    output logic                         o_mosi,
    input  wire                          i_miso
);

    localparam logic [7:0] HALF_LAST = 8'(`IO_SPI_HALF_BIT - 1);

    periph_pkg::spi_state_t state;
    periph_pkg::spi_byte_t  tx_shift;
    periph_pkg::spi_byte_t  rx_shift;
    logic [7:0]             div_cnt;
    logic [3:0]             half_cnt;
    logic                   half_end;

    // Last cycle of a half-bit, SCLK toggles on this edge
    assign half_end = (state == periph_pkg::SPI_SHIFT) && (div_cnt == HALF_LAST);

    // --------------------------------------------------
    // Control: 16 half-bits, start cycle counts as the first
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= periph_pkg::SPI_IDLE;
            o_sclk   <= 1'b0;
            div_cnt  <= 8'd0;
            half_cnt <= 4'd0;
            o_rx     <= '0;
        end
        else
        begin
            case (state)
                periph_pkg::SPI_IDLE:
                begin
                    if (i_start)
                    begin
                        state    <= periph_pkg::SPI_SHIFT;
                        div_cnt  <= 8'd1;
                        half_cnt <= 4'd0;
                    end
                end
                periph_pkg::SPI_SHIFT:
                begin
                    if (half_end)
                    begin
                        div_cnt  <= 8'd0;
                        o_sclk   <= ~o_sclk;
                        half_cnt <= half_cnt + 4'd1;
                        if (half_cnt == 4'd15)
                        begin
                            state <= periph_pkg::SPI_END;
                            o_rx  <= rx_shift;
                        end
                    end
                    else
                        div_cnt <= div_cnt + 8'd1;
                end
                periph_pkg::SPI_END:
                    state <= periph_pkg::SPI_IDLE;
                default:
                    state <= periph_pkg::SPI_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Data: MOSI moves on falling SCLK, MISO taken on rising
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            tx_shift <= '0;
        else if (state == periph_pkg::SPI_IDLE && i_start)
            tx_shift <= i_tx;
        else if (half_end && o_sclk)
            tx_shift <= {tx_shift[6:0], 1'b0};
    end

    always_ff @(posedge clk)
    begin
        if (half_end && !o_sclk)
            rx_shift <= {rx_shift[6:0], i_miso};
    end

    assign o_mosi = tx_shift[7];
    assign o_done = (state == periph_pkg::SPI_END);

    // Sequencer waits for done before it can start another byte
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        i_start |-> state == periph_pkg::SPI_IDLE);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the I/O unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module io_unit_tb

out=$(./obj_dir/Vio_unit_tb)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

/* sources.f */
+incdir+logic
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/io_registers.sv
logic/spi_master.sv
logic/os_timer.sv
logic/bus_sequencer.sv
logic/io_unit.sv
verification/spi_slave_model.sv
verification/io_unit_tb.sv

/* verification/io_unit_tb.sv */
// I/O unit testbench: clock, reset, random bus traffic, reference model, checks, timeout
`default_nettype none

`include "io_defs.svh"

module io_unit_tb;

    // Timer phase is about 2 x 1600 cycles, all other phases under 2000 together
    localparam int MAX_CYCLES     = 20000;
    // SPI start in cycle 1, its done 16 half-bits later, bus done one cycle after that
    localparam int SPI_DONE_CYCLE = 1 + 16 * `IO_SPI_HALF_BIT + 1;
    localparam int UNMAPPED_CYCLE = 1 + `IO_UNMAPPED_DELAY;

    logic                  clk;
    logic                  reset;
    bus_pkg::addr_t        bus_addr;
    bus_pkg::word_t        bus_data;
    logic                  bus_we;
    logic                  bus_start;
    bus_pkg::word_t        bus_q;
    logic                  bus_done;
    logic                  spi_sclk;
    logic                  spi_mosi;
    logic                  spi_miso;
    logic                  spi_cs;
    logic                  spi_nint;
    periph_pkg::gpio_t     gpi;
    periph_pkg::gpio_t     gpo;
    logic                  t1_irq;
    logic                  t2_irq;
    logic                  boot_mode;
    periph_pkg::spi_byte_t slave_tx;
    periph_pkg::spi_byte_t slave_rx;
    logic [15:0]           slave_bad_high;

    integer seed;
    int     cycle;
    int     errors;
    int     checks;

    // Reference model
    logic                  exp_cs;
    periph_pkg::gpio_t     exp_gpo;
    periph_pkg::spi_byte_t exp_spi_rx;
    int                    deadline [2];
    bit                    armed [2];

    io_unit dut (
        .clk         (clk),
        .reset       (reset),
        .i_bus_addr  (bus_addr),
        .i_bus_data  (bus_data),
        .i_bus_we    (bus_we),
        .i_bus_start (bus_start),
        .o_bus_q     (bus_q),
        .o_bus_done  (bus_done),
        .o_spi_sclk  (spi_sclk),
        .o_spi_mosi  (spi_mosi),
        .i_spi_miso  (spi_miso),
        .o_spi_cs    (spi_cs),
        .i_spi_nint  (spi_nint),
        .i_gpi       (gpi),
        .o_gpo       (gpo),
        .o_t1_irq    (t1_irq),
        .o_t2_irq    (t2_irq),
        .i_boot_mode (boot_mode)
    );

    spi_slave_model slave (
        .clk        (clk),
        .i_sclk     (spi_sclk),
        .i_mosi     (spi_mosi),
        .i_cs       (spi_cs),
        .i_tx_byte  (slave_tx),
        .o_miso     (spi_miso),
        .o_rx_byte  (slave_rx),
        .o_bad_high (slave_bad_high)
    );

    always #10 clk = ~clk;

    // --------------------------------------------------
    // Cycle count and watchdog
    // --------------------------------------------------
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES)
        begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error: %s is 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle);
        end
    endtask

    // Interrupt due exactly at the deadline, never elsewhere
    task automatic check_irq(input int idx, input logic irq);
        if (armed[idx] && cycle == deadline[idx])
        begin
            armed[idx] = 1'b0;
            checks++;
            assert (irq === 1'b1)
            else
            begin
                errors++;
                $display("Timer %0d gave no interrupt at cycle %0d", idx + 1, cycle);
            end
        end
        else
        begin
            assert (irq === 1'b0)
            else
            begin
                errors++;
                $display("Timer %0d interrupt at cycle %0d was not expected", idx + 1, cycle);
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_irq(0, t1_irq);
            check_irq(1, t2_irq);
        end
    end

    // --------------------------------------------------
    // Bus master
    // --------------------------------------------------
    // Done cycle counts the accept edge as cycle 1
    task automatic bus_access(input bus_pkg::addr_t addr, input bus_pkg::word_t data,
                              input logic we, output bus_pkg::word_t q,
                              output int done_cycle);
        int n;
        n = 0;
        bus_addr  = addr;
        bus_data  = data;
        bus_we    = we;
        bus_start = 1'b1;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (bus_done !== 1'b1);
        q          = bus_q;
        done_cycle = n + 1;
        bus_start  = 1'b0;
        bus_we     = 1'b0;
        // Sequencer needs start low in its release state
        @(negedge clk);
        @(negedge clk);
    endtask

    task automatic write_reg(input bus_pkg::addr_t addr, input bus_pkg::word_t data,
                             input int exp_cycle);
        bus_pkg::word_t q;
        int             done_cycle;
        bus_access(addr, data, 1'b1, q, done_cycle);
        check_value("o_bus_done cycle", done_cycle, exp_cycle);
    endtask

    task automatic read_check(input bus_pkg::addr_t addr, input bus_pkg::word_t exp_q,
                              input int exp_cycle, input string name);
        bus_pkg::word_t q;
        int             done_cycle;
        bus_access(addr, '0, 1'b0, q, done_cycle);
        check_value(name, q, exp_q);
        check_value("o_bus_done cycle", done_cycle, exp_cycle);
    endtask

    function automatic bit is_mapped(input bus_pkg::addr_t addr);
        return addr inside {`IO_A_SPI_DATA, `IO_A_SPI_CS, `IO_A_SPI_NINT, `IO_A_GPIO,
                            `IO_A_T1_VAL, `IO_A_T1_CTRL, `IO_A_T2_VAL, `IO_A_T2_CTRL,
                            `IO_A_BOOT};
    endfunction

    // --------------------------------------------------
    // Test rounds
    // --------------------------------------------------
    task automatic register_round();
        int             pick;
        bus_pkg::word_t data;
        pick = $random(seed) & 3;
        data = $random(seed);
        case (pick)
            0:
            begin
                exp_gpo = data[7:4];
                write_reg(`IO_A_GPIO, data, 2);
                check_value("o_gpo", 32'(gpo), 32'(exp_gpo));
                gpi = periph_pkg::gpio_t'($random(seed));
                read_check(`IO_A_GPIO, {24'd0, exp_gpo, gpi}, 2, "o_bus_q (GPIO)");
            end
            1:
            begin
                exp_cs = data[0];
                write_reg(`IO_A_SPI_CS, data, 2);
                check_value("o_spi_cs", 32'(spi_cs), 32'(exp_cs));
                read_check(`IO_A_SPI_CS, 32'(exp_cs), 2, "o_bus_q (SPI CS)");
            end
            2:
            begin
                spi_nint = data[0];
                read_check(`IO_A_SPI_NINT, 32'(data[0]), 2, "o_bus_q (SPI nint)");
            end
            default:
            begin
                boot_mode = data[0];
                read_check(`IO_A_BOOT, 32'(data[0]), 2, "o_bus_q (boot mode)");
            end
        endcase
    endtask

    task automatic spi_round();
        bus_pkg::word_t data;
        data     = $random(seed);
        slave_tx = periph_pkg::spi_byte_t'($random(seed));
        write_reg(`IO_A_SPI_DATA, data, SPI_DONE_CYCLE);
        check_value("MOSI byte", 32'(slave_rx), 32'(data[7:0]));
        exp_spi_rx = slave_tx;
        read_check(`IO_A_SPI_DATA, 32'(exp_spi_rx), 2, "o_bus_q (SPI data)");
    endtask

    // Go is seen on the next rising edge, the one that raises done
    task automatic start_timer(input int idx, input bus_pkg::addr_t ctrl_addr,
                               input int value);
        deadline[idx] = cycle + 1 + value;
        armed[idx]    = (value != 0);
        write_reg(ctrl_addr, 32'd1, 2);
    endtask

    task automatic timer_run(input int idx, input int value, input bit restart);
        bus_pkg::addr_t val_addr;
        bus_pkg::addr_t ctrl_addr;
        val_addr  = (idx == 0) ? `IO_A_T1_VAL : `IO_A_T2_VAL;
        ctrl_addr = (idx == 0) ? `IO_A_T1_CTRL : `IO_A_T2_CTRL;
        write_reg(val_addr, value, 2);
        if (restart)
        begin
            start_timer(idx, ctrl_addr, value);
            repeat (value / 4) @(negedge clk);
        end
        start_timer(idx, ctrl_addr, value);
        // Long enough to catch a late or a second pulse
        repeat (value + 40) @(negedge clk);
    endtask

    task automatic unmapped_round();
        bus_pkg::addr_t addr;
        bus_pkg::word_t q;
        int             done_cycle;
        logic           we;
        // Half of them land close to the register block
        do
        begin
            addr = bus_pkg::addr_t'($random(seed));
            if (addr[0])
                addr = 27'hC02700 + 27'(addr[7:1]);
        end
        while (is_mapped(addr));
        we = $random(seed) & 1;
        bus_access(addr, $random(seed), we, q, done_cycle);
        check_value("o_bus_done cycle", done_cycle, UNMAPPED_CYCLE);
        if (!we)
            check_value("o_bus_q (unmapped)", q, 32'd0);
        check_value("o_spi_cs", 32'(spi_cs), 32'(exp_cs));
        check_value("o_gpo", 32'(gpo), 32'(exp_gpo));
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        seed        = 353;
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        bus_addr    = '0;
        bus_data    = '0;
        bus_we      = 1'b0;
        bus_start   = 1'b0;
        spi_nint    = 1'b0;
        gpi         = '0;
        boot_mode   = 1'b0;
        slave_tx    = '0;
        exp_cs      = 1'b1;
        exp_gpo     = '0;
        exp_spi_rx  = '0;
        deadline[0] = 0;
        deadline[1] = 0;
        armed[0]    = 1'b0;
        armed[1]    = 1'b0;

        repeat (4) @(negedge clk);
        reset = 1'b0;

        check_value("o_bus_done", 32'(bus_done), 32'd0);
        check_value("o_spi_cs", 32'(spi_cs), 32'd1);
        check_value("o_gpo", 32'(gpo), 32'd0);
        check_value("o_spi_sclk", 32'(spi_sclk), 32'd0);
        check_value("o_t1_irq", 32'(t1_irq), 32'd0);
        check_value("o_t2_irq", 32'(t2_irq), 32'd0);

        repeat (60) register_round();

        // Slave listens only with chip select low
        exp_cs = 1'b0;
        write_reg(`IO_A_SPI_CS, 32'd0, 2);
        repeat (12) spi_round();
        check_value("SCLK high phases of wrong length", 32'(slave_bad_high), 32'd0);
        exp_cs = 1'b1;
        write_reg(`IO_A_SPI_CS, 32'd1, 2);

        for (int i = 0; i < 2; i++)
        begin
            timer_run(i, 1, 1'b0);
            repeat (5) timer_run(i, 1 + (($random(seed) & 32'h7fffffff) % 300), 1'b0);
            timer_run(i, 40 + (($random(seed) & 32'h7fffffff) % 261), 1'b1);
            timer_run(i, 0, 1'b0);
        end

        read_check(`IO_A_T1_VAL, 32'd0, 2, "o_bus_q (T1 value)");
        read_check(`IO_A_T1_CTRL, 32'd0, 2, "o_bus_q (T1 control)");
        read_check(`IO_A_T2_VAL, 32'd0, 2, "o_bus_q (T2 value)");
        read_check(`IO_A_T2_CTRL, 32'd0, 2, "o_bus_q (T2 control)");
        repeat (40) unmapped_round();

        repeat (10) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/spi_slave_model.sv */
// SPI slave model: MOSI byte capture, MISO byte return, SCLK high-time check
`default_nettype none

`include "io_defs.svh"

module spi_slave_model (
    input  wire                          clk,
    input  wire                          i_sclk,
    input  wire                          i_mosi,
    input  wire                          i_cs,
    input  wire periph_pkg::spi_byte_t   i_tx_byte,
    output logic                         o_miso,
    output periph_pkg::spi_byte_t        o_rx_byte,
    output logic [15:0]                  o_bad_high
);

    logic [2:0] bit_cnt;
    logic [7:0] high_len;
    logic       sclk_q;

    initial
    begin
        bit_cnt    = 3'd0;
        high_len   = 8'd0;
        sclk_q     = 1'b0;
        o_rx_byte  = '0;
        o_bad_high = 16'd0;
    end

    // Mode 0: MSB out before the first rise, next bit after each fall
    assign o_miso = i_tx_byte[3'd7 - bit_cnt];

    always @(posedge i_sclk)
        o_rx_byte <= {o_rx_byte[6:0], i_mosi};

    // CS high parks the pointer on the MSB
    always @(negedge i_sclk or posedge i_cs)
    begin
        if (i_cs)
            bit_cnt <= 3'd0;
        else
            bit_cnt <= bit_cnt + 3'd1;
    end

    // Every SCLK high phase should last one half-bit of clk cycles
    always @(negedge clk)
    begin
        if (i_sclk === 1'b1)
            high_len <= high_len + 8'd1;
        else
        begin
            if (sclk_q === 1'b1 && high_len != 8'(`IO_SPI_HALF_BIT))
                o_bad_high <= o_bad_high + 16'd1;
            high_len <= 8'd0;
        end
        sclk_q <= i_sclk;
    end

endmodule

`default_nettype wire
